// File: source/bitcnt_pkg.sv
// ======================================================================
// Shared widths, vector types and opcodes of the bit-count unit
// Widths are fixed for RV64; word forms act on the low 32 bits only
// ======================================================================

package bitcnt_pkg;

   // Operand width and word-form width
   localparam int XLEN  = 64;
   localparam int WLEN  = 32;

   // Index of a bit within a dword
   localparam int IDX_W = $clog2(XLEN);
   // One extra bit so a count can reach XLEN itself
   localparam int CNT_W = IDX_W + 1;

   // Operands, shaped vectors and results
   typedef logic [XLEN-1:0]  dword_t;

   // Lowest-set-bit position, 0 to 63
   typedef logic [IDX_W-1:0] bit_idx_t;

   // Count from 0 to 64
   typedef logic [CNT_W-1:0] count_t;

   // Zbb bit-count opcodes
   typedef enum logic [2:0]
   {
      OP_CLZ   = 3'd0,
      OP_CTZ   = 3'd1,
      OP_CPOP  = 3'd2,
      OP_CLZW  = 3'd3,
      OP_CTZW  = 3'd4,
      OP_CPOPW = 3'd5
   } bitcnt_op_t;

endpackage

// File: source/rte64_gs.sv
// ======================================================================
// Lowest-set-bit encoder over 64 bits, purely combinational
// dout is only meaningful while gs is high
// ======================================================================

`timescale 1ns/100ps

module rte64_gs
   import bitcnt_pkg::*;
(
   input  dword_t   din,
   output bit_idx_t dout,
   output logic     gs
);

   // Leaves look at bit pairs
   logic       lf_idx [XLEN/2];
   logic       lf_any [XLEN/2];
   // Merge levels, index grows one bit per level
   logic [1:0] m1_idx [XLEN/4];
   logic       m1_any [XLEN/4];
   logic [2:0] m2_idx [XLEN/8];
   logic       m2_any [XLEN/8];
   logic [3:0] m3_idx [XLEN/16];
   logic       m3_any [XLEN/16];
   logic [4:0] m4_idx [XLEN/32];
   logic       m4_any [XLEN/32];

   genvar g;

   // Leaf picks the upper bit only when the lower one is clear
   for (g = 0; g < XLEN/2; g++)
   begin : g_leaf
      assign lf_idx[g] = ~din[2*g] & din[2*g+1];
      assign lf_any[g] = din[2*g] | din[2*g+1];
   end

   // Lower half wins when it holds a set bit
   for (g = 0; g < XLEN/4; g++)
   begin : g_m1
      assign m1_idx[g] = lf_any[2*g] ? {1'b0, lf_idx[2*g]} : {1'b1, lf_idx[2*g+1]};
      assign m1_any[g] = lf_any[2*g] | lf_any[2*g+1];
   end

   for (g = 0; g < XLEN/8; g++)
   begin : g_m2
      assign m2_idx[g] = m1_any[2*g] ? {1'b0, m1_idx[2*g]} : {1'b1, m1_idx[2*g+1]};
      assign m2_any[g] = m1_any[2*g] | m1_any[2*g+1];
   end

   for (g = 0; g < XLEN/16; g++)
   begin : g_m3
      assign m3_idx[g] = m2_any[2*g] ? {1'b0, m2_idx[2*g]} : {1'b1, m2_idx[2*g+1]};
      assign m3_any[g] = m2_any[2*g] | m2_any[2*g+1];
   end

   for (g = 0; g < XLEN/32; g++)
   begin : g_m4
      assign m4_idx[g] = m3_any[2*g] ? {1'b0, m3_idx[2*g]} : {1'b1, m3_idx[2*g+1]};
      assign m4_any[g] = m3_any[2*g] | m3_any[2*g+1];
   end

   // Root node, upper half prefix is bit 5
   assign dout = m4_any[0] ? {1'b0, m4_idx[0]} : {1'b1, m4_idx[1]};
   assign gs   = m4_any[0] | m4_any[1];

endmodule

// File: source/bitcnt_operand_prep.sv
// ======================================================================
// First stage of the bit-count unit
// Shapes the operand per opcode and registers it, one cycle latency
// Vectors and opcode load only on issue; stage_valid alone is reset
// ======================================================================

`timescale 1ns/100ps

module bitcnt_operand_prep
   import bitcnt_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       issue,
   input  bitcnt_op_t op,
   input  dword_t     operand,
   output logic       stage_valid,
   output bitcnt_op_t stage_op,
   output dword_t     enc_vec,
   output dword_t     pop_vec
);

   // Full and word bit reversals
   dword_t            rev_d;
   logic [WLEN-1:0]   rev_w;
   // Shaped vectors ahead of the registers
   dword_t            enc_next;
   dword_t            pop_next;

   // Leading counts become trailing counts after reversal
   always_comb
   begin
      for (int i = 0; i < XLEN; i++)
      begin
         rev_d[i] = operand[XLEN-1-i];
      end
      for (int i = 0; i < WLEN; i++)
      begin
         rev_w[i] = operand[WLEN-1-i];
      end
   end

   always_comb
   begin
      // Trailing count and full popcount take the operand as is
      enc_next = operand;
      pop_next = operand;
      case (op)
         OP_CLZ:
         begin
            enc_next = rev_d;
         end
         OP_CLZW:
         begin
            // Guard at bit 32 caps a zero word at 32
            enc_next = {{(XLEN-WLEN-1){1'b0}}, 1'b1, rev_w};
         end
         OP_CTZW:
         begin
            enc_next = {{(XLEN-WLEN-1){1'b0}}, 1'b1, operand[WLEN-1:0]};
         end
         OP_CPOPW:
         begin
            // Upper half must not count
            pop_next = {{(XLEN-WLEN){1'b0}}, operand[WLEN-1:0]};
         end
         default:
         begin
         end
      endcase
   end

   // Valid strobe, delayed one cycle
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         stage_valid <= 1'b0;
      end
      else
      begin
         stage_valid <= issue;
      end
   end

   // Payload registers
   always_ff @(posedge clk)
   begin
      if (issue)
      begin
         stage_op <= op;
         enc_vec  <= enc_next;
         pop_vec  <= pop_next;
      end
   end

endmodule

// File: source/popcount64.sv
// ======================================================================
// Population count over 64 bits, purely combinational
// Adder tree of six levels; output range is 0 to 64
// ======================================================================

`timescale 1ns/100ps

module popcount64
   import bitcnt_pkg::*;
(
   input  dword_t din,
   output count_t cnt
);

   // Partial sums, each level one bit wider
   logic [1:0] s2 [XLEN/2];
   logic [2:0] s3 [XLEN/4];
   logic [3:0] s4 [XLEN/8];
   logic [4:0] s5 [XLEN/16];
   logic [5:0] s6 [XLEN/32];

   genvar g;

   // Bit pairs, 0 to 2
   for (g = 0; g < XLEN/2; g++)
   begin : g_s2
      assign s2[g] = {1'b0, din[2*g]} + {1'b0, din[2*g+1]};
   end

   // Nibbles, 0 to 4
   for (g = 0; g < XLEN/4; g++)
   begin : g_s3
      assign s3[g] = {1'b0, s2[2*g]} + {1'b0, s2[2*g+1]};
   end

   // Bytes, 0 to 8
   for (g = 0; g < XLEN/8; g++)
   begin : g_s4
      assign s4[g] = {1'b0, s3[2*g]} + {1'b0, s3[2*g+1]};
   end

   // Halfwords, 0 to 16
   for (g = 0; g < XLEN/16; g++)
   begin : g_s5
      assign s5[g] = {1'b0, s4[2*g]} + {1'b0, s4[2*g+1]};
   end

   // Words, 0 to 32
   for (g = 0; g < XLEN/32; g++)
   begin : g_s6
      assign s6[g] = {1'b0, s5[2*g]} + {1'b0, s5[2*g+1]};
   end

   // Final sum needs the seventh bit for 64
   assign cnt = {1'b0, s6[0]} + {1'b0, s6[1]};

endmodule

// File: source/bitcnt_result_stage.sv
// ======================================================================
// Second stage of the bit-count unit
// Turns encoder or popcount output into a zero-extended result
// result loads only with stage_valid; done alone is reset
// ======================================================================

`timescale 1ns/100ps

module bitcnt_result_stage
   import bitcnt_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       stage_valid,
   input  bitcnt_op_t stage_op,
   input  bit_idx_t   enc_idx,
   input  logic       enc_any,
   input  count_t     pop_cnt,
   output logic       done,
   output dword_t     result
);

   count_t enc_cnt;
   count_t sel_cnt;

   // No set bit found means a full-width count
   assign enc_cnt = enc_any ? {1'b0, enc_idx} : count_t'(XLEN);

   // Popcount class versus encoder class
   always_comb
   begin
      case (stage_op)
         OP_CPOP,
         OP_CPOPW: sel_cnt = pop_cnt;
         default:  sel_cnt = enc_cnt;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         done <= 1'b0;
      end
      else
      begin
         done <= stage_valid;
      end
   end

   // Zero-extend into the dword result
   always_ff @(posedge clk)
   begin
      if (stage_valid)
      begin
         result <= dword_t'(sel_cnt);
      end
   end

endmodule

// File: source/bitcnt_unit.sv
// ======================================================================
// Zbb bit-count unit: clz, ctz, cpop and their word forms
// Fixed latency of two cycles, one issue per cycle, no back-pressure
// done is a single-cycle pulse and must be taken when it appears
// ======================================================================

`timescale 1ns/100ps

module bitcnt_unit
   import bitcnt_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       issue,
   input  bitcnt_op_t op,
   input  dword_t     operand,
   output logic       done,
   output dword_t     result
);

   // Stage one outputs
   logic       stage_valid;
   bitcnt_op_t stage_op;
   dword_t     enc_vec;
   dword_t     pop_vec;

   // Combinational counters between the stages
   bit_idx_t   enc_idx;
   logic       enc_any;
   count_t     pop_cnt;

   // Operand shaping and first register
   bitcnt_operand_prep i_prep
   (
      .clk         (clk),
      .arst_n      (arst_n),
      .issue       (issue),
      .op          (op),
      .operand     (operand),
      .stage_valid (stage_valid),
      .stage_op    (stage_op),
      .enc_vec     (enc_vec),
      .pop_vec     (pop_vec)
   );

   // Lowest set bit of the shaped vector
   rte64_gs i_enc
   (
      .din  (enc_vec),
      .dout (enc_idx),
      .gs   (enc_any)
   );

   popcount64 i_pop
   (
      .din (pop_vec),
      .cnt (pop_cnt)
   );

   // Count select and output register
   bitcnt_result_stage i_result
   (
      .clk         (clk),
      .arst_n      (arst_n),
      .stage_valid (stage_valid),
      .stage_op    (stage_op),
      .enc_idx     (enc_idx),
      .enc_any     (enc_any),
      .pop_cnt     (pop_cnt),
      .done        (done),
      .result      (result)
   );

endmodule

// File: tb/bitcnt_tb.sv
// ======================================================================
// Directed testbench for the Zbb bit-count unit
// Inputs change and outputs are sampled on the falling clock edge
// Expected results come from a loop-based model of the count rules
// ======================================================================

`timescale 1ns/100ps

module bitcnt_tb
   import bitcnt_pkg::*;
();

   // Falling edges to wait for done before giving up
   localparam int TIMEOUT = 20;

   logic       clk;
   logic       arst_n;
   logic       issue;
   bitcnt_op_t op;
   dword_t     operand;
   logic       done;
   dword_t     result;

   // Error and check bookkeeping
   int         mismatch_count;
   int         failure_count;
   int         check_count;

   // Streaming state with results expected in issue order
   dword_t     exp_q [$];
   int         issue_count;
   int         done_count;
   // Issue history one and two falling edges back
   logic       issued_d1;
   logic       issued_d2;

   bitcnt_unit i_dut
   (
      .clk     (clk),
      .arst_n  (arst_n),
      .issue   (issue),
      .op      (op),
      .operand (operand),
      .done    (done),
      .result  (result)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #50 clk = ~clk;
      end
   end

   // Zeros from bit 0 upward up to width
   function automatic int trailing_zeros(input dword_t v, input int width);
      int n;
      n = 0;
      while (n < width && v[n] == 1'b0)
      begin
         n++;
      end
      return n;
   endfunction

   // Zeros from bit width-1 downward
   function automatic int leading_zeros(input dword_t v, input int width);
      int n;
      n = 0;
      while (n < width && v[width-1-n] == 1'b0)
      begin
         n++;
      end
      return n;
   endfunction

   function automatic int ones_count(input dword_t v, input int width);
      int n;
      n = 0;
      for (int i = 0; i < width; i++)
      begin
         n += v[i];
      end
      return n;
   endfunction

   // Reference result per opcode, zero-extended
   function automatic dword_t model_result(input bitcnt_op_t m_op, input dword_t m_val);
      int n;
      case (m_op)
         OP_CLZ:   n = leading_zeros(m_val, XLEN);
         OP_CTZ:   n = trailing_zeros(m_val, XLEN);
         OP_CPOP:  n = ones_count(m_val, XLEN);
         OP_CLZW:  n = leading_zeros(m_val, WLEN);
         OP_CTZW:  n = trailing_zeros(m_val, WLEN);
         OP_CPOPW: n = ones_count(m_val, WLEN);
         default:  n = 0;
      endcase
      return dword_t'(n);
   endfunction

   // Random dword right-shifted so leading counts spread out
   function automatic dword_t random_operand();
      dword_t v;
      v = {$urandom, $urandom};
      return v >> ($urandom % XLEN);
   endfunction

   task automatic compare_result(input dword_t expected);
      check_count++;
      if (result !== expected)
      begin
         mismatch_count++;
         $display("mismatch at %0t: result expected %0h actual %0h",
                  $time, expected, result);
      end
   endtask

   // Reset for 5 cycles then idle with done held low
   task automatic check_reset();
      for (int c = 0; c < 9; c++)
      begin
         @(negedge clk);
         if (c == 4)
         begin
            arst_n = 1'b1;
         end
         check_count++;
         if (done !== 1'b0)
         begin
            mismatch_count++;
            $display("mismatch at %0t: done expected 0 actual %b", $time, done);
         end
      end
   endtask

   // One operation alone with done expected two cycles after issue
   task automatic run_op(input bitcnt_op_t t_op, input dword_t t_val, input dword_t t_exp);
      int   cyc;
      logic seen;
      cyc  = 0;
      seen = 1'b0;
      @(negedge clk);
      op      = t_op;
      operand = t_val;
      issue   = 1'b1;
      while (!seen && cyc < TIMEOUT)
      begin
         @(negedge clk);
         issue = 1'b0;
         cyc++;
         if (done === 1'b1)
         begin
            seen = 1'b1;
         end
      end
      if (!seen)
      begin
         failure_count++;
         $display("Timed out waiting for done after %s of %0h", t_op.name(), t_val);
      end
      else
      begin
         check_count++;
         if (cyc != 2)
         begin
            failure_count++;
            $display("done came %0d cycles after issue instead of 2 at %0t", cyc, $time);
         end
         compare_result(t_exp);
      end
   endtask

   // Each opcode with one set bit at every position
   task automatic walk_single_bits();
      bitcnt_op_t w_op;
      dword_t     w_val;
      for (int k = 0; k < 6; k++)
      begin
         w_op = bitcnt_op_t'(k);
         for (int pos = 0; pos < XLEN; pos++)
         begin
            w_val = dword_t'(1) << pos;
            run_op(w_op, w_val, model_result(w_op, w_val));
         end
      end
   endtask

   // Zero and all-ones corners with fixed expected counts
   task automatic check_edges();
      run_op(OP_CLZ, '0, 64);
      run_op(OP_CTZ, '0, 64);
      // Upper half must be ignored by word forms
      run_op(OP_CLZW, 64'hA5A5_C3C3_0000_0000, 32);
      run_op(OP_CTZW, 64'hA5A5_C3C3_0000_0000, 32);
      run_op(OP_CPOP, '1, 64);
      run_op(OP_CPOPW, '1, 32);
   endtask

   task automatic start_stream();
      exp_q.delete();
      issue_count = 0;
      done_count  = 0;
      issued_d1   = 1'b0;
      issued_d2   = 1'b0;
   endtask

   // One falling edge of streaming traffic that checks done before driving
   task automatic pipe_step(input logic do_issue);
      bitcnt_op_t s_op;
      dword_t     s_val;
      @(negedge clk);
      check_count++;
      if (done === 1'b1 && !issued_d2)
      begin
         failure_count++;
         $display("done pulse at %0t without a matching issue two cycles earlier", $time);
      end
      else if (done !== 1'b1 && issued_d2)
      begin
         failure_count++;
         $display("done pulse missing at %0t for an issue two cycles earlier", $time);
      end
      if (done === 1'b1)
      begin
         done_count++;
         if (exp_q.size() == 0)
         begin
            failure_count++;
            $display("done pulse at %0t with no operation outstanding", $time);
         end
         else
         begin
            compare_result(exp_q.pop_front());
         end
      end
      issued_d2 = issued_d1;
      issued_d1 = do_issue;
      issue     = do_issue;
      if (do_issue)
      begin
         s_op    = bitcnt_op_t'($urandom % 6);
         s_val   = random_operand();
         op      = s_op;
         operand = s_val;
         exp_q.push_back(model_result(s_op, s_val));
         issue_count++;
      end
   endtask

   // Idle until every outstanding result is back
   task automatic drain_stream(input string label);
      int w;
      w = 0;
      while ((exp_q.size() > 0 || issued_d1 || issued_d2) && w < TIMEOUT)
      begin
         pipe_step(1'b0);
         w++;
      end
      if (exp_q.size() > 0)
      begin
         failure_count++;
         $display("%s: timed out with %0d results never returned", label, exp_q.size());
      end
      // A few more idle edges to catch stray pulses
      pipe_step(1'b0);
      pipe_step(1'b0);
      check_count++;
      if (done_count != issue_count)
      begin
         failure_count++;
         $display("%s: %0d done pulses for %0d issues", label, done_count, issue_count);
      end
   endtask

   // Issues on every cycle with two operations in flight
   task automatic burst_traffic(input int n);
      start_stream();
      for (int k = 0; k < n; k++)
      begin
         pipe_step(1'b1);
      end
      drain_stream("burst");
   endtask

   // Random idle gaps of 0 to 3 cycles between issues
   task automatic gapped_traffic(input int n);
      int idle;
      start_stream();
      for (int k = 0; k < n; k++)
      begin
         idle = $urandom % 4;
         repeat (idle)
         begin
            pipe_step(1'b0);
         end
         pipe_step(1'b1);
      end
      drain_stream("gapped");
   endtask

   initial
   begin
      void'($urandom(21505));
      arst_n         = 1'b0;
      issue          = 1'b0;
      op             = OP_CLZ;
      operand        = '0;
      mismatch_count = 0;
      failure_count  = 0;
      check_count    = 0;
      start_stream();

      check_reset();
      walk_single_bits();
      check_edges();
      burst_traffic(200);
      gapped_traffic(150);

      $display("Summary: %0d checks, %0d mismatches, %0d other failures",
               check_count, mismatch_count, failure_count);
      if (mismatch_count == 0 && failure_count == 0)
      begin
         $display("*** PASSED ***");
      end
      else
      begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// File: bitcnt.f
source/bitcnt_pkg.sv
source/rte64_gs.sv
source/bitcnt_operand_prep.sv
source/popcount64.sv
source/bitcnt_result_stage.sv
source/bitcnt_unit.sv
tb/bitcnt_tb.sv
